//--- hw/hsdBoard_config.svh
`ifndef HSD_BOARD_CONFIG_SVH
`define HSD_BOARD_CONFIG_SVH

////////////////////////////////////////////////////////////
// Identification

// Word returned at the build-date register
`define HSD_BUILD_DATE 32'hC0DE51A5

////////////////////////////////////////////////////////////
// Timekeeping and trigger sizing

// Scaled down for simulation
`define HSD_TICKS_PER_US 5
`define HSD_US_PER_SECOND 50

`define HSD_TRIGGER_COUNT 8
`define HSD_SOFT_STRETCH 8
`define HSD_STRETCH_BITS 4

`endif

//--- hw/hsdPkg.sv
`include "hsdBoard_config.svh"

package hsdPkg;

    ////////////////////////////////////////////////////////////
    // Register bus

    typedef logic [31:0] csrWord;

    // Index 7 is left unmapped
    typedef enum logic [2:0] {
        RegBuildDate    = 3'd0,
        RegMicroseconds = 3'd1,
        RegSeconds      = 3'd2,
        RegUserStatus   = 3'd3,
        RegInterlock    = 3'd4,
        RegSpiMux       = 3'd5,
        RegSoftTrigger  = 3'd6
    } regIndex;

    localparam int RegCount = 7;

    // One write strobe per mapped register
    typedef logic [RegCount-1:0] regStrobes;

    ////////////////////////////////////////////////////////////
    // Trigger strobes

    // Software trigger in bit 0, event triggers above it
    localparam int SoftTrigBit  = 0;
    localparam int EventTrigLsb = 1;

    typedef logic [`HSD_TRIGGER_COUNT:0] trigStrobes;

endpackage

//--- hw/csrBus.sv
`timescale 1ns/1ps
`include "hsdBoard_config.svh"

module csrBus import hsdPkg::*; (
    input  logic      sysClk,
    input  logic      rstN,
    input  logic      csrWrite,
    input  regIndex   csrAddr,
    input  csrWord    csrWData,
    input  csrWord    usecWord,
    input  csrWord    secWord,
    input  csrWord    userWord,
    input  csrWord    interlockWord,
    input  csrWord    spiMuxWord,
    output regStrobes wrStrobes,
    output csrWord    csrRData
);

    localparam csrWord UnmappedWord = 32'hDEADBEEF;

    ////////////////////////////////////////////////////////////
    // Write decode

    // One strobe for the addressed register, none for index 7
    always_comb begin
        wrStrobes = '0;
        if (csrWrite && (csrAddr < RegCount)) begin
            wrStrobes[csrAddr] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Readback

    // Registered mux, data follows the address by one cycle
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            csrRData <= '0;
        end else begin
            case (csrAddr)
                RegBuildDate: begin
                    csrRData <= `HSD_BUILD_DATE;
                end
                RegMicroseconds: begin
                    csrRData <= usecWord;
                end
                RegSeconds: begin
                    csrRData <= secWord;
                end
                RegUserStatus: begin
                    csrRData <= userWord;
                end
                RegInterlock: begin
                    csrRData <= interlockWord;
                end
                RegSpiMux: begin
                    csrRData <= spiMuxWord;
                end
                // Soft trigger is write-only
                RegSoftTrigger: begin
                    csrRData <= '0;
                end
                default: begin
                    csrRData <= UnmappedWord;
                end
            endcase
        end
    end

    strobeOneHot: assert property (@(posedge sysClk) disable iff (!rstN)
        $onehot0(wrStrobes))
        else $error("csrBus: more than one write strobe active");

endmodule

//--- hw/uptimeCounters.sv
`timescale 1ns/1ps
`include "hsdBoard_config.svh"

module uptimeCounters import hsdPkg::*; (
    input  logic   sysClk,
    input  logic   rstN,
    output csrWord usecWord,
    output csrWord secWord
);

    localparam int TickBits = $clog2(`HSD_TICKS_PER_US);
    localparam int UsecBits = $clog2(`HSD_US_PER_SECOND);

    logic [TickBits-1:0] tickCount;
    logic [UsecBits-1:0] usecInSecond;
    logic                usecTick;

    ////////////////////////////////////////////////////////////
    // Microsecond prescaler

    assign usecTick = (tickCount == TickBits'(`HSD_TICKS_PER_US - 1));

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            tickCount <= '0;
        end else if (usecTick) begin
            tickCount <= '0;
        end else begin
            tickCount <= tickCount + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Uptime counters

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            usecWord     <= '0;
            secWord      <= '0;
            usecInSecond <= '0;
        end else if (usecTick) begin
            usecWord <= usecWord + 1'b1;
            // Roll into the next second
            if (usecInSecond == UsecBits'(`HSD_US_PER_SECOND - 1)) begin
                usecInSecond <= '0;
                secWord      <= secWord + 1'b1;
            end else begin
                usecInSecond <= usecInSecond + 1'b1;
            end
        end
    end

    secondsFollowUsec: assert property (@(posedge sysClk) disable iff (!rstN)
        (secWord != $past(secWord)) |-> (usecWord != $past(usecWord)))
        else $error("uptimeCounters: seconds moved without a microsecond tick");

endmodule

//--- hw/triggerConditioner.sv
`timescale 1ns/1ps
`include "hsdBoard_config.svh"

module triggerConditioner import hsdPkg::*; (
    input  logic                          sysClk,
    input  logic                          rstN,
    input  logic                          softStrobe,
    input  logic [`HSD_TRIGGER_COUNT-1:0] eventTriggers,
    output logic [`HSD_TRIGGER_COUNT-1:0] syncTriggers,
    output hsdPkg::trigStrobes            trigStrobes
);

    localparam logic [`HSD_STRETCH_BITS-1:0] StretchLoad = `HSD_SOFT_STRETCH;

    logic [`HSD_TRIGGER_COUNT-1:0] eventMeta;
    logic [`HSD_STRETCH_BITS-1:0]  stretchCount;
    logic                          softLevel;
    logic [`HSD_TRIGGER_COUNT:0]   levelNow;
    logic [`HSD_TRIGGER_COUNT:0]   levelDelayed;

    ////////////////////////////////////////////////////////////
    // Event trigger synchronizer

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            eventMeta    <= '0;
            syncTriggers <= '0;
        end else begin
            eventMeta    <= eventTriggers;
            syncTriggers <= eventMeta;
        end
    end

    ////////////////////////////////////////////////////////////
    // Software trigger stretch

    // A new write reloads the count, so a repeat only extends the level
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            stretchCount <= '0;
        end else if (softStrobe) begin
            stretchCount <= StretchLoad;
        end else if (stretchCount != '0) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    assign softLevel = (stretchCount != '0);

    ////////////////////////////////////////////////////////////
    // Rising edge strobes

    always_comb begin
        levelNow = '0;
        levelNow[SoftTrigBit] = softLevel;
        levelNow[EventTrigLsb +: `HSD_TRIGGER_COUNT] = syncTriggers;
    end

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            levelDelayed <= '0;
            trigStrobes  <= '0;
        end else begin
            levelDelayed <= levelNow;
            trigStrobes  <= levelNow & ~levelDelayed;
        end
    end

    singleCycleStrobe: assert property (@(posedge sysClk) disable iff (!rstN)
        (trigStrobes & $past(trigStrobes)) == '0)
        else $error("triggerConditioner: strobe held for two cycles");

endmodule

//--- hw/panelControls.sv
`timescale 1ns/1ps
`include "hsdBoard_config.svh"

module panelControls import hsdPkg::*; (
    input  logic                          sysClk,
    input  logic                          rstN,
    input  logic                          interlockStrobe,
    input  logic                          spiMuxStrobe,
    input  csrWord                        csrWData,
    input  logic                          switchWest,
    input  logic                          switchEast,
    input  logic                          switchNorth,
    input  logic [7:0]                    dipSwitch,
    input  logic [`HSD_TRIGGER_COUNT-1:0] syncTriggers,
    input  logic [1:0]                    secLow,
    output logic                          interlockRelayControl,
    output logic                          spiMuxSel0,
    output logic                          spiMuxSel1,
    output logic [7:0]                    leds,
    output csrWord                        userWord,
    output csrWord                        interlockWord,
    output csrWord                        spiMuxWord
);

    // No relay feedback on this board, status is fixed
    localparam logic RelayClosed = 1'b1;
    localparam logic RelayOpen   = 1'b0;

    logic [10:0] switchMeta;
    logic [10:0] switchSync;
    logic        recoverySwitch;
    logic        displaySwitch;
    logic        resetButton;

    ////////////////////////////////////////////////////////////
    // Switch synchronizers

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            switchMeta <= '0;
            switchSync <= '0;
        end else begin
            switchMeta <= {switchNorth, switchEast, switchWest, dipSwitch};
            switchSync <= switchMeta;
        end
    end

    assign recoverySwitch = switchSync[8];
    assign displaySwitch  = switchSync[9];
    assign resetButton    = switchSync[10];

    ////////////////////////////////////////////////////////////
    // Relay and clock-chip SPI mux

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            interlockRelayControl <= 1'b0;
            spiMuxSel0            <= 1'b0;
            spiMuxSel1            <= 1'b0;
        end else begin
            if (interlockStrobe) begin
                interlockRelayControl <= csrWData[0];
            end
            if (spiMuxStrobe) begin
                spiMuxSel0 <= csrWData[0];
                spiMuxSel1 <= csrWData[1];
            end
        end
    end

    // Status words
    assign userWord = {recoverySwitch, displaySwitch, 6'b0, syncTriggers, 8'b0,
                       switchSync[7:0]};
    assign interlockWord = {28'b0, RelayClosed, RelayOpen, 1'b0, resetButton};
    assign spiMuxWord    = {30'b0, spiMuxSel1, spiMuxSel0};

    assign leds = {resetButton, RelayOpen, RelayClosed, interlockRelayControl,
                   secLow, syncTriggers[1:0]};

endmodule

//--- hw/hsdTop.sv
`timescale 1ns/1ps
`include "hsdBoard_config.svh"

module hsdTop import hsdPkg::*; (
    input  logic                          sysClk,
    input  logic                          rstN,
    input  logic                          csrWrite,
    input  regIndex                       csrAddr,
    input  csrWord                        csrWData,
    input  logic [`HSD_TRIGGER_COUNT-1:0] eventTriggers,
    input  logic                          switchWest,
    input  logic                          switchEast,
    input  logic                          switchNorth,
    input  logic [7:0]                    dipSwitch,
    output csrWord                        csrRData,
    output trigStrobes                    triggerStrobes,
    output logic                          interlockRelayControl,
    output logic                          spiMuxSel0,
    output logic                          spiMuxSel1,
    output logic [7:0]                    leds
);

    csrWord                        usecWord;
    csrWord                        secWord;
    csrWord                        userWord;
    csrWord                        interlockWord;
    csrWord                        spiMuxWord;
    regStrobes                     wrStrobes;
    logic [`HSD_TRIGGER_COUNT-1:0] syncTriggers;

    ////////////////////////////////////////////////////////////
    // Register bus and peers

    csrBus csrBus0 (
        .sysClk(sysClk), .rstN(rstN), .csrWrite(csrWrite), .csrAddr(csrAddr),
        .csrWData(csrWData), .usecWord(usecWord), .secWord(secWord),
        .userWord(userWord), .interlockWord(interlockWord),
        .spiMuxWord(spiMuxWord), .wrStrobes(wrStrobes), .csrRData(csrRData));

    uptimeCounters uptime0 (
        .sysClk(sysClk), .rstN(rstN), .usecWord(usecWord), .secWord(secWord));

    triggerConditioner trigger0 (
        .sysClk(sysClk), .rstN(rstN), .softStrobe(wrStrobes[RegSoftTrigger]),
        .eventTriggers(eventTriggers), .syncTriggers(syncTriggers),
        .trigStrobes(triggerStrobes));

    panelControls panel0 (
        .sysClk(sysClk), .rstN(rstN),
        .interlockStrobe(wrStrobes[RegInterlock]),
        .spiMuxStrobe(wrStrobes[RegSpiMux]), .csrWData(csrWData),
        .switchWest(switchWest), .switchEast(switchEast),
        .switchNorth(switchNorth), .dipSwitch(dipSwitch),
        .syncTriggers(syncTriggers), .secLow(secWord[1:0]),
        .interlockRelayControl(interlockRelayControl), .spiMuxSel0(spiMuxSel0),
        .spiMuxSel1(spiMuxSel1), .leds(leds), .userWord(userWord),
        .interlockWord(interlockWord), .spiMuxWord(spiMuxWord));

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int HalfPeriod  = 10,
    parameter int ResetCycles = 10
) (
    output logic sysClk,
    output logic rstN
);

    initial begin
        sysClk = 1'b0;
        forever begin
            #HalfPeriod sysClk = ~sysClk;
        end
    end

    // Reset low for the first cycles
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge sysClk);
        rstN <= 1'b1;
    end

endmodule

//--- sim/hsdTb.sv
`timescale 1ns/1ps
`include "hsdBoard_config.svh"

module hsdTb import hsdPkg::*; ();

    localparam int MaxOps   = 64;
    localparam int WatchLen = 5;
    localparam int OpEnd    = 0;
    localparam int OpWrite  = 1;
    localparam int OpRead   = 2;
    localparam int OpWait   = 3;
    localparam int OpTrig   = 4;
    localparam int OpSwitch = 5;
    localparam int OpWatch  = 6;
    localparam int OpPins   = 7;
    localparam int OpLeds   = 8;

    logic                          sysClk;
    logic                          rstN;
    logic                          csrWrite;
    regIndex                       csrAddr;
    csrWord                        csrWData;
    logic [`HSD_TRIGGER_COUNT-1:0] eventTriggers;
    logic                          switchWest;
    logic                          switchEast;
    logic                          switchNorth;
    logic [7:0]                    dipSwitch;
    csrWord                        csrRData;
    trigStrobes                    triggerStrobes;
    logic                          interlockRelayControl;
    logic                          spiMuxSel0;
    logic                          spiMuxSel1;
    logic [7:0]                    leds;

    // Three words per golden entry for op, index and value
    csrWord goldenMem [0:3*MaxOps-1];
    int     cycleLimit = 0;
    int     cycleCount = 0;
    bit     running = 1'b0;

    clockGen clockGen0 (.sysClk(sysClk), .rstN(rstN));

    hsdTop dut0 (
        .sysClk(sysClk), .rstN(rstN), .csrWrite(csrWrite), .csrAddr(csrAddr),
        .csrWData(csrWData), .eventTriggers(eventTriggers), .switchWest(switchWest),
        .switchEast(switchEast), .switchNorth(switchNorth), .dipSwitch(dipSwitch),
        .csrRData(csrRData), .triggerStrobes(triggerStrobes),
        .interlockRelayControl(interlockRelayControl), .spiMuxSel0(spiMuxSel0),
        .spiMuxSel1(spiMuxSel1), .leds(leds));

    ////////////////////////////////////////////////////////////
    // Result checks

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "hsdTb stopped at the first error");
    endtask

    task automatic checkWord(input string name, input csrWord got, input csrWord exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0d ns: %s expected %h got %h",
                              $time, name, exp, got));
        end
    endtask

    task automatic checkStrobes(input trigStrobes got, input trigStrobes exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0d ns: triggerStrobes expected %h got %h",
                              $time, exp, got));
        end
    endtask

    task automatic checkLeds(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0d ns: leds expected %b got %b", $time, exp, got));
        end
    endtask

    // Pins packed as {spiMuxSel1, spiMuxSel0, interlockRelayControl}
    task automatic checkPins(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0d ns: {spiMuxSel1,spiMuxSel0,relay} expected %b got %b",
                              $time, exp, got));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and strobe operations

    task automatic busWrite(input csrWord idx, input csrWord value);
        csrWrite <= 1'b1;
        csrAddr  <= regIndex'(idx[2:0]);
        csrWData <= value;
        @(posedge sysClk);
        csrWrite <= 1'b0;
    endtask

    // Readback lags the address by one edge
    task automatic busRead(input csrWord idx, input csrWord exp);
        csrAddr <= regIndex'(idx[2:0]);
        @(posedge sysClk);
        @(negedge sysClk);
        checkWord("csrRData", csrRData, exp);
        @(posedge sysClk);
    endtask

    // Expected strobe only at hitCycle, zero in every other cycle of the window
    task automatic watchStrobes(input int hitCycle, input trigStrobes exp);
        trigStrobes want;
        for (int k = 1; k <= WatchLen; k++) begin
            want = (k == hitCycle) ? exp : '0;
            @(posedge sysClk);
            @(negedge sysClk);
            checkStrobes(triggerStrobes, want);
        end
        @(posedge sysClk);
    endtask

    // Sum of the wait entries sets the timeout
    task automatic loadGolden();
        int entry;
        int waitTotal;
        bit atEnd;
        // Words the file does not reach keep a pattern that is no valid op
        for (int i = 0; i < 3*MaxOps; i++) begin
            goldenMem[i] = ~csrWord'(i);
        end
        $readmemh("sim/hsd_golden.txt", goldenMem);
        entry = 0;
        waitTotal = 0;
        atEnd = 1'b0;
        while (!atEnd) begin
            if ($isunknown(goldenMem[3*entry]) || goldenMem[3*entry] > OpLeds) begin
                failRun("golden file is missing or holds a bad op");
            end else if (goldenMem[3*entry] == OpEnd) begin
                atEnd = 1'b1;
            end else if (entry == MaxOps - 1) begin
                failRun("golden file has no end entry");
            end else begin
                if (goldenMem[3*entry] == OpWait) begin
                    waitTotal += int'(goldenMem[3*entry+2]);
                end
                entry++;
            end
        end
        if (entry == 0) begin
            failRun("golden file holds no operations");
        end else begin
            cycleLimit = waitTotal + 200;
        end
    endtask

    always @(posedge sysClk) begin
        if (running) begin
            cycleCount <= cycleCount + 1;
            if (cycleCount >= cycleLimit) begin
                failRun($sformatf("timeout: golden run not done after %0d cycles", cycleCount));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Golden sequence

    initial begin
        int     pc;
        int     opCode;
        int     opIndex;
        csrWord opValue;
        csrWrite      = 1'b0;
        csrAddr       = RegBuildDate;
        csrWData      = '0;
        eventTriggers = '0;
        switchWest    = 1'b0;
        switchEast    = 1'b0;
        switchNorth   = 1'b0;
        dipSwitch     = '0;
        loadGolden();
        @(posedge rstN);
        running = 1'b1;
        pc = 0;
        opCode = int'(goldenMem[0]);
        while (opCode != OpEnd) begin
            opIndex = int'(goldenMem[3*pc+1]);
            opValue = goldenMem[3*pc+2];
            case (opCode)
                OpWrite: busWrite(opIndex, opValue);
                OpRead: busRead(opIndex, opValue);
                OpWait: repeat (opValue) @(posedge sysClk);
                OpTrig: eventTriggers <= opValue[`HSD_TRIGGER_COUNT-1:0];
                OpSwitch: begin
                    dipSwitch   <= opValue[7:0];
                    switchWest  <= opValue[8];
                    switchEast  <= opValue[9];
                    switchNorth <= opValue[10];
                end
                OpWatch: watchStrobes(opIndex, opValue[$bits(trigStrobes)-1:0]);
                OpPins: begin
                    @(negedge sysClk);
                    checkPins({spiMuxSel1, spiMuxSel0, interlockRelayControl}, opValue[2:0]);
                    @(posedge sysClk);
                end
                OpLeds: begin
                    @(negedge sysClk);
                    checkLeds(leds, opValue[7:0]);
                    @(posedge sysClk);
                end
                default: failRun($sformatf("unknown golden op %0d at entry %0d", opCode, pc));
            endcase
            pc++;
            opCode = int'(goldenMem[3*pc]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- sim/hsd_golden.txt
// Columns: op index value, hex. Ops: 1 write, 2 read/expect, 3 wait, 4 set triggers,
// 5 set switches {north,east,west,dip}, 6 watch strobes (index = hit cycle), 7 pins, 8 leds, 0 end
3 0 00000208
2 1 00000068
2 2 00000002
8 0 00000028
2 0 C0DE51A5
2 7 DEADBEEF
1 4 00000001
7 0 00000001
8 0 00000038
2 4 00000008
1 5 00000002
7 0 00000005
2 5 00000002
1 4 00000000
7 0 00000004
4 0 00000004
6 3 00000008
6 0 00000000
2 3 00040000
4 0 00000005
6 3 00000002
8 0 00000029
4 0 00000000
1 6 00000001
6 1 00000001
1 6 00000001
6 0 00000000
5 0 000005A5
3 0 00000002
2 3 800000A5
8 0 000000A8
2 4 00000009
0 0 00000000

//--- src.f
+incdir+hw
hw/hsdPkg.sv
hw/csrBus.sv
hw/uptimeCounters.sv
hw/triggerConditioner.sv
hw/panelControls.sv
hw/hsdTop.sv
sim/clockGen.sv
sim/hsdTb.sv

//--- run.sh
#!/bin/sh
# Build and run the hsdTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f src.f --top-module hsdTb -o hsdSim

./obj_dir/hsdSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
